// File: design/tri_mem_cfg.svh
// Line-refill memory configuration: address, line, way and memory sizes
`ifndef TRI_MEM_CFG_SVH
`define TRI_MEM_CFG_SVH

// Physical address width
`define TRI_PLEN 32

// Cache line is 16 bytes
`define TRI_LINE_WIDTH 128
`define TRI_LINE_OFFSET 4

// Backing store size, index width must match
`define TRI_MEM_LINES 64
`define TRI_MEM_IDX_W 6

// Victim way width, same for both caches
`define TRI_WAY_W 2

`endif

// File: design/tri_mem_pkg.sv
// Shared types for the line-refill memory: payload vectors, request structs, enums
`default_nettype none

`include "tri_mem_cfg.svh"

package tri_mem_pkg;

  typedef logic [`TRI_PLEN-1:0]       paddr_t;
  typedef logic [`TRI_LINE_WIDTH-1:0] line_t;
  typedef logic [`TRI_WAY_W-1:0]      way_t;
  typedef logic [`TRI_MEM_IDX_W-1:0]  line_idx_t;

  // Requester of a memory access
  typedef enum logic [1:0] {
    SRC_IC = 2'd0,
    SRC_DC = 2'd1,
    SRC_WB = 2'd2
  } req_src_e;

  typedef struct packed {
    paddr_t paddr;
    way_t   way;
  } miss_req_t;

  typedef struct packed {
    paddr_t paddr;
    way_t   way;
    line_t  data;
  } refill_t;

  typedef struct packed {
    paddr_t paddr;
    line_t  data;
  } wb_req_t;

  // A read tagged SRC_WB is an idle slot
  typedef struct packed {
    logic      we;
    line_idx_t idx;
    line_t     wdata;
    req_src_e  src;
  } mem_req_t;

  typedef struct packed {
    logic     valid;
    req_src_e src;
    line_t    data;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    MP_IDLE,
    MP_WAIT_GRANT,
    MP_WAIT_DATA,
    MP_REFILL
  } miss_state_e;

endpackage

`default_nettype wire

// File: design/miss_port.sv
// Miss port: holds one outstanding cache miss and returns its refill
`timescale 1ns/1ps
`default_nettype none

`include "tri_mem_cfg.svh"

module miss_port
  import tri_mem_pkg::*;
#(
  parameter req_src_e SRC = SRC_IC
) (
  input  wire logic      clk_i,
  input  wire logic      arst_n_i,

  // Miss request from the cache
  input  wire logic      miss_valid_i,
  output logic           miss_ready_o,
  input  wire miss_req_t miss_req_i,

  // Refill back to the cache
  output logic           refill_valid_o,
  input  wire logic      refill_ready_i,
  output refill_t        refill_o,

  // Arbiter side
  output logic           rd_req_o,
  output line_idx_t      rd_idx_o,
  input  wire logic      grant_i,

  // Shared memory response
  input  wire mem_rsp_t  mem_rsp_i
);

  miss_state_e state_q, state_d;
  miss_req_t   req_q;
  line_t       data_q;
  logic        rsp_hit;

  // Only our own tagged response counts
  assign rsp_hit = mem_rsp_i.valid && (mem_rsp_i.src == SRC) && (state_q == MP_WAIT_DATA);

  assign miss_ready_o   = (state_q == MP_IDLE);
  assign rd_req_o       = (state_q == MP_WAIT_GRANT);
  assign refill_valid_o = (state_q == MP_REFILL);
  assign rd_idx_o       = req_q.paddr[`TRI_LINE_OFFSET +: `TRI_MEM_IDX_W];

  // Refill address is line aligned
  assign refill_o = '{
    paddr: {req_q.paddr[`TRI_PLEN-1:`TRI_LINE_OFFSET], {`TRI_LINE_OFFSET{1'b0}}},
    way:   req_q.way,
    data:  data_q
  };

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MP_IDLE: begin
        if (miss_valid_i) state_d = MP_WAIT_GRANT;
      end
      MP_WAIT_GRANT: begin
        if (grant_i) state_d = MP_WAIT_DATA;
      end
      MP_WAIT_DATA: begin
        if (rsp_hit) state_d = MP_REFILL;
      end
      MP_REFILL: begin
        if (refill_ready_i) state_d = MP_IDLE;
      end
      default: state_d = MP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= MP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Miss payload and returned line
  always_ff @(posedge clk_i) begin
    if (miss_valid_i && miss_ready_o) begin
      req_q <= miss_req_i;
    end
    if (rsp_hit) begin
      data_q <= mem_rsp_i.data;
    end
  end

endmodule

`default_nettype wire

// File: design/mem_arbiter.sv
// Round-robin arbiter between the two miss ports and the writeback channel
`timescale 1ns/1ps
`default_nettype none

`include "tri_mem_cfg.svh"

module mem_arbiter
  import tri_mem_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      arst_n_i,

  input  wire logic      ic_req_i,
  input  wire line_idx_t ic_idx_i,
  input  wire logic      dc_req_i,
  input  wire line_idx_t dc_idx_i,

  output logic           ic_grant_o,
  output logic           dc_grant_o,

  input  wire logic      wb_valid_i,
  input  wire wb_req_t   wb_req_i,
  output logic           wb_ready_o,

  output mem_req_t       mem_req_o
);

  req_src_e   ptr_q;
  req_src_e   cand;
  req_src_e   winner;
  req_src_e   sel_src;
  logic       any_req;
  logic [2:0] req_vec;

  // Next requester in rotation order
  function automatic req_src_e rr_step(input req_src_e src);
    case (src)
      SRC_IC:  rr_step = SRC_DC;
      SRC_DC:  rr_step = SRC_WB;
      default: rr_step = SRC_IC;
    endcase
  endfunction

  assign req_vec = {wb_valid_i, dc_req_i, ic_req_i};

  // First requester at or after the pointer wins
  always_comb begin
    cand    = ptr_q;
    winner  = ptr_q;
    any_req = 1'b0;
    for (int i = 0; i < 3; i++) begin
      if (!any_req && req_vec[cand]) begin
        winner  = cand;
        any_req = 1'b1;
      end
      cand = rr_step(cand);
    end
  end

  assign ic_grant_o = any_req && (winner == SRC_IC);
  assign dc_grant_o = any_req && (winner == SRC_DC);
  assign wb_ready_o = any_req && (winner == SRC_WB);

  // Idle cycles issue a read tagged SRC_WB, which memory ignores
  assign sel_src = any_req ? winner : SRC_WB;

  always_comb begin
    mem_req_o.we    = wb_ready_o;
    mem_req_o.src   = sel_src;
    mem_req_o.wdata = wb_req_i.data;
    unique case (sel_src)
      SRC_IC:  mem_req_o.idx = ic_idx_i;
      SRC_DC:  mem_req_o.idx = dc_idx_i;
      default: mem_req_o.idx = wb_req_i.paddr[`TRI_LINE_OFFSET +: `TRI_MEM_IDX_W];
    endcase
  end

  // Pointer moves past the last winner
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= SRC_IC;
    end else if (any_req) begin
      ptr_q <= rr_step(winner);
    end
  end

endmodule

`default_nettype wire

// File: design/line_memory.sv
// Line RAM: full-line writes, one-cycle tagged reads
`timescale 1ns/1ps
`default_nettype none

`include "tri_mem_cfg.svh"

module line_memory
  import tri_mem_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  input  wire mem_req_t mem_req_i,
  output mem_rsp_t      mem_rsp_o
);

  line_t    mem_q [`TRI_MEM_LINES];
  line_t    rsp_data_q;
  req_src_e rsp_src_q;
  logic     rsp_valid_q;
  logic     rd_en;

  // Writeback never reads, so its tag marks an empty slot
  assign rd_en = !mem_req_i.we && (mem_req_i.src != SRC_WB);

  always_ff @(posedge clk_i) begin
    if (mem_req_i.we) begin
      mem_q[mem_req_i.idx] <= mem_req_i.wdata;
    end
    if (rd_en) begin
      rsp_data_q <= mem_q[mem_req_i.idx];
      rsp_src_q  <= mem_req_i.src;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= rd_en;
    end
  end

  assign mem_rsp_o = '{valid: rsp_valid_q, src: rsp_src_q, data: rsp_data_q};

endmodule

`default_nettype wire

// File: design/tri_mem_subsys.sv
// Memory subsystem top: I$ and D$ miss ports, writeback and arbiter on one line RAM
`timescale 1ns/1ps
`default_nettype none

module tri_mem_subsys
  import tri_mem_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      arst_n_i,

  // I-cache miss and refill
  input  wire logic      icache_miss_req_valid_i,
  output logic           icache_miss_req_ready_o,
  input  wire miss_req_t icache_miss_req_i,

  output logic           icache_refill_valid_o,
  input  wire logic      icache_refill_ready_i,
  output refill_t        icache_refill_o,

  // D-cache miss and refill
  input  wire logic      dcache_miss_req_valid_i,
  output logic           dcache_miss_req_ready_o,
  input  wire miss_req_t dcache_miss_req_i,

  output logic           dcache_refill_valid_o,
  input  wire logic      dcache_refill_ready_i,
  output refill_t        dcache_refill_o,

  // D-cache writeback
  input  wire logic      dcache_wb_req_valid_i,
  output logic           dcache_wb_req_ready_o,
  input  wire wb_req_t   dcache_wb_req_i
);

  logic      ic_rd_req;
  line_idx_t ic_rd_idx;
  logic      ic_grant;
  logic      dc_rd_req;
  line_idx_t dc_rd_idx;
  logic      dc_grant;
  mem_req_t  mem_req;
  mem_rsp_t  mem_rsp;

  miss_port #(
    .SRC(SRC_IC)
  ) u_ic_port (
    .clk_i,
    .arst_n_i,
    .miss_valid_i   (icache_miss_req_valid_i),
    .miss_ready_o   (icache_miss_req_ready_o),
    .miss_req_i     (icache_miss_req_i),
    .refill_valid_o (icache_refill_valid_o),
    .refill_ready_i (icache_refill_ready_i),
    .refill_o       (icache_refill_o),
    .rd_req_o       (ic_rd_req),
    .rd_idx_o       (ic_rd_idx),
    .grant_i        (ic_grant),
    .mem_rsp_i      (mem_rsp)
  );

  miss_port #(
    .SRC(SRC_DC)
  ) u_dc_port (
    .clk_i,
    .arst_n_i,
    .miss_valid_i   (dcache_miss_req_valid_i),
    .miss_ready_o   (dcache_miss_req_ready_o),
    .miss_req_i     (dcache_miss_req_i),
    .refill_valid_o (dcache_refill_valid_o),
    .refill_ready_i (dcache_refill_ready_i),
    .refill_o       (dcache_refill_o),
    .rd_req_o       (dc_rd_req),
    .rd_idx_o       (dc_rd_idx),
    .grant_i        (dc_grant),
    .mem_rsp_i      (mem_rsp)
  );

  // Writeback goes straight in, its ready is the grant
  mem_arbiter u_arb (
    .clk_i,
    .arst_n_i,
    .ic_req_i   (ic_rd_req),
    .ic_idx_i   (ic_rd_idx),
    .dc_req_i   (dc_rd_req),
    .dc_idx_i   (dc_rd_idx),
    .ic_grant_o (ic_grant),
    .dc_grant_o (dc_grant),
    .wb_valid_i (dcache_wb_req_valid_i),
    .wb_req_i   (dcache_wb_req_i),
    .wb_ready_o (dcache_wb_req_ready_o),
    .mem_req_o  (mem_req)
  );

  line_memory u_mem (
    .clk_i,
    .arst_n_i,
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp)
  );

endmodule

`default_nettype wire

// File: bench/tri_mem_sva.sv
// Handshake assertions for the memory subsystem: refill hold, single grant, reset state
`timescale 1ns/1ps
`default_nettype none

module tri_mem_sva
  import tri_mem_pkg::*;
(
  input wire logic    clk_i,
  input wire logic    arst_n_i,
  input wire logic    ic_refill_valid_i,
  input wire logic    ic_refill_ready_i,
  input wire refill_t ic_refill_i,
  input wire logic    dc_refill_valid_i,
  input wire logic    dc_refill_ready_i,
  input wire refill_t dc_refill_i,
  input wire logic    ic_grant_i,
  input wire logic    dc_grant_i,
  input wire logic    wb_grant_i
);

  // Refill held with its payload until taken
  ic_refill_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ic_refill_valid_i && !ic_refill_ready_i |=> ic_refill_valid_i && $stable(ic_refill_i))
    else $error("I-cache refill dropped or changed before ready");

  dc_refill_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dc_refill_valid_i && !dc_refill_ready_i |=> dc_refill_valid_i && $stable(dc_refill_i))
    else $error("D-cache refill dropped or changed before ready");

  one_grant: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({ic_grant_i, dc_grant_i, wb_grant_i}))
    else $error("More than one grant in a cycle");

  refill_low_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !ic_refill_valid_i && !dc_refill_valid_i)
    else $error("Refill valid high right after reset");

endmodule

bind tri_mem_subsys tri_mem_sva u_sva (
  .clk_i             (clk_i),
  .arst_n_i          (arst_n_i),
  .ic_refill_valid_i (icache_refill_valid_o),
  .ic_refill_ready_i (icache_refill_ready_i),
  .ic_refill_i       (icache_refill_o),
  .dc_refill_valid_i (dcache_refill_valid_o),
  .dc_refill_ready_i (dcache_refill_ready_i),
  .dc_refill_i       (dcache_refill_o),
  .ic_grant_i        (ic_grant),
  .dc_grant_i        (dc_grant),
  .wb_grant_i        (dcache_wb_req_ready_o)
);

`default_nettype wire

// File: bench/tb_tri_mem_subsys.sv
// Testbench for the memory subsystem with random miss and writeback traffic against a line model
`timescale 1ns/1ps
`default_nettype none

`include "tri_mem_cfg.svh"

module tb_tri_mem_subsys
  import tri_mem_pkg::*;
();

  localparam int N_ALIAS = 32;
  localparam int N_BP    = 16;
  localparam int N_CONT  = 40;
  // Preload writebacks, readback misses from both caches, then the random phases
  localparam int N_REQ   = 3 * `TRI_MEM_LINES + 2 * N_ALIAS + 2 * N_BP + 3 * N_CONT;
  localparam int TIMEOUT = 20 * N_REQ + 200;

  logic      clk_i;
  logic      arst_n_i;
  logic      ic_miss_valid, ic_miss_ready, ic_refill_valid, ic_refill_ready;
  logic      dc_miss_valid, dc_miss_ready, dc_refill_valid, dc_refill_ready;
  logic      wb_valid, wb_ready;
  miss_req_t ic_miss, dc_miss;
  refill_t   ic_refill, dc_refill;
  wb_req_t   wb_req;

  line_t     model [`TRI_MEM_LINES];
  miss_req_t mq [2][256];
  int        mq_head [2];
  int        mq_tail [2];
  wb_req_t   wq [256];
  int        wq_head;
  int        wq_tail;
  logic      mv [2];
  logic      rr [2];
  logic      outst [2];
  logic      held [2];
  miss_req_t mreq [2];
  miss_req_t exp_req [2];
  refill_t   held_rf [2];
  logic      wv;
  logic      bp_mode;
  integer    seed;
  int        cycles = 0;

  tri_mem_subsys UUT (
    .clk_i                   (clk_i),
    .arst_n_i                (arst_n_i),
    .icache_miss_req_valid_i (ic_miss_valid),
    .icache_miss_req_ready_o (ic_miss_ready),
    .icache_miss_req_i       (ic_miss),
    .icache_refill_valid_o   (ic_refill_valid),
    .icache_refill_ready_i   (ic_refill_ready),
    .icache_refill_o         (ic_refill),
    .dcache_miss_req_valid_i (dc_miss_valid),
    .dcache_miss_req_ready_o (dc_miss_ready),
    .dcache_miss_req_i       (dc_miss),
    .dcache_refill_valid_o   (dc_refill_valid),
    .dcache_refill_ready_i   (dc_refill_ready),
    .dcache_refill_o         (dc_refill),
    .dcache_wb_req_valid_i   (wb_valid),
    .dcache_wb_req_ready_o   (wb_ready),
    .dcache_wb_req_i         (wb_req)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: traffic did not drain within %0d cycles", TIMEOUT);
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic check(input string name, input logic [191:0] exp, input logic [191:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  function automatic line_idx_t line_of(input paddr_t a);
    return line_idx_t'((a >> `TRI_LINE_OFFSET) % `TRI_MEM_LINES);
  endfunction

  function automatic paddr_t align(input paddr_t a);
    return a & ~((paddr_t'(1) << `TRI_LINE_OFFSET) - paddr_t'(1));
  endfunction

  // No writeback to a line that a miss holds, and no miss to a line being written
  function automatic logic wb_blocked(input paddr_t a);
    logic hit;
    hit = 1'b0;
    for (int c = 0; c < 2; c++) begin
      hit |= mv[c] && (line_of(mreq[c].paddr) == line_of(a));
      hit |= outst[c] && (line_of(exp_req[c].paddr) == line_of(a));
    end
    return hit;
  endfunction

  task automatic push_miss(input int c, input paddr_t a);
    mq[c][mq_tail[c]] = '{paddr: a, way: way_t'($random(seed))};
    mq_tail[c]++;
  endtask

  task automatic push_wb(input paddr_t a);
    line_t d;
    d = {$random(seed), $random(seed), $random(seed), $random(seed)};
    wq[wq_tail] = '{paddr: a, data: d};
    wq_tail++;
  endtask

  // Drive on the falling edge and score the handshakes of the next rising edge
  task automatic step();
    logic    rv [2];
    logic    mr [2];
    refill_t rf [2];
    @(negedge clk_i);
    for (int c = 0; c < 2; c++) begin
      if (!mv[c] && mq_head[c] != mq_tail[c] && ($random(seed) & 3) != 0 &&
          !(wv && line_of(wb_req.paddr) == line_of(mq[c][mq_head[c]].paddr))) begin
        mreq[c] = mq[c][mq_head[c]];
        mq_head[c]++;
        mv[c] = 1'b1;
      end
      rr[c] = bp_mode ? ($random(seed) & 1) : 1'b1;
    end
    if (!wv && wq_head != wq_tail && ($random(seed) & 3) != 0 &&
        !wb_blocked(wq[wq_head].paddr)) begin
      wb_req = wq[wq_head];
      wq_head++;
      wv = 1'b1;
    end
    ic_miss_valid   = mv[0];
    ic_miss         = mreq[0];
    ic_refill_ready = rr[0];
    dc_miss_valid   = mv[1];
    dc_miss         = mreq[1];
    dc_refill_ready = rr[1];
    wb_valid        = wv;
    #1;
    rv = '{ic_refill_valid, dc_refill_valid};
    mr = '{ic_miss_ready, dc_miss_ready};
    rf = '{ic_refill, dc_refill};
    for (int c = 0; c < 2; c++) begin
      if (held[c]) begin
        check(c ? "dc refill valid held" : "ic refill valid held", 1'b1, rv[c]);
        check(c ? "dc refill payload held" : "ic refill payload held", held_rf[c], rf[c]);
      end
      if (rv[c]) begin
        check(c ? "dc miss ready in refill" : "ic miss ready in refill", 1'b0, mr[c]);
      end
      if (rv[c] && rr[c]) begin
        check(c ? "dc refill outstanding" : "ic refill outstanding", 1'b1, outst[c]);
        check(c ? "dc refill" : "ic refill",
              {align(exp_req[c].paddr), exp_req[c].way, model[line_of(exp_req[c].paddr)]},
              rf[c]);
        outst[c] = 1'b0;
      end
      held[c]    = rv[c] && !rr[c];
      held_rf[c] = rf[c];
      if (mv[c] && mr[c]) begin
        exp_req[c] = mreq[c];
        outst[c]   = 1'b1;
        mv[c]      = 1'b0;
      end
    end
    if (!wv) begin
      check("wb ready without request", 1'b0, wb_ready);
    end
    if (wv && wb_ready) begin
      model[line_of(wb_req.paddr)] = wb_req.data;
      wv = 1'b0;
    end
  endtask

  task automatic drain();
    while (mq_head[0] != mq_tail[0] || mq_head[1] != mq_tail[1] || wq_head != wq_tail ||
           mv[0] || mv[1] || outst[0] || outst[1] || wv) begin
      step();
    end
  endtask

  initial begin
    seed     = 93080;
    clk_i    = 1'b0;
    arst_n_i = 1'b0;
    bp_mode  = 1'b0;
    wv       = 1'b0;
    wq_head  = 0;
    wq_tail  = 0;
    wb_valid = 1'b0;
    wb_req   = '0;
    for (int c = 0; c < 2; c++) begin
      mv[c]      = 1'b0;
      rr[c]      = 1'b1;
      outst[c]   = 1'b0;
      held[c]    = 1'b0;
      mreq[c]    = '0;
      exp_req[c] = '0;
      mq_head[c] = 0;
      mq_tail[c] = 0;
    end
    ic_miss_valid   = 1'b0;
    ic_miss         = '0;
    ic_refill_ready = 1'b1;
    dc_miss_valid   = 1'b0;
    dc_miss         = '0;
    dc_refill_ready = 1'b1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    #1;
    check("reset ic refill valid", 1'b0, ic_refill_valid);
    check("reset dc refill valid", 1'b0, dc_refill_valid);
    check("reset ic miss ready", 1'b1, ic_miss_ready);
    check("reset dc miss ready", 1'b1, dc_miss_ready);

    // Preload every line, then read each one back from both caches
    for (int i = 0; i < `TRI_MEM_LINES; i++) begin
      push_wb((paddr_t'(i) << `TRI_LINE_OFFSET) | paddr_t'($random(seed) & 4'hf));
    end
    drain();
    for (int i = 0; i < `TRI_MEM_LINES; i++) begin
      push_miss(0, (paddr_t'(i) << `TRI_LINE_OFFSET) | paddr_t'($random(seed) & 4'hf));
      push_miss(1, (paddr_t'(i) << `TRI_LINE_OFFSET) | paddr_t'($random(seed) & 4'hf));
    end
    drain();

    // Full-width addresses alias onto the memory lines
    for (int i = 0; i < N_ALIAS; i++) begin
      push_miss(0, paddr_t'($random(seed)));
      push_miss(1, paddr_t'($random(seed)));
    end
    drain();

    bp_mode = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      push_miss(0, paddr_t'($random(seed)));
      push_miss(1, paddr_t'($random(seed)));
    end
    drain();

    // All three channels at once
    for (int i = 0; i < N_CONT; i++) begin
      push_miss(0, paddr_t'($random(seed)));
      push_miss(1, paddr_t'($random(seed)));
      push_wb(paddr_t'($random(seed)));
    end
    drain();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+design
design/tri_mem_pkg.sv
design/miss_port.sv
design/mem_arbiter.sv
design/line_memory.sv
design/tri_mem_subsys.sv
bench/tri_mem_sva.sv
bench/tb_tri_mem_subsys.sv

// File: Bender.yml
package:
  name: tri_mem_subsys

sources:
  - include_dirs:
      - design
    files:
      - design/tri_mem_pkg.sv
      - design/miss_port.sv
      - design/mem_arbiter.sv
      - design/line_memory.sv
      - design/tri_mem_subsys.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/tri_mem_sva.sv
      - bench/tb_tri_mem_subsys.sv
